//--- files.f
+incdir+verilog
verilog/renamePkg.sv
verilog/stageReg.sv
verilog/dispatchStage.sv
verilog/regStatusFile.sv
verilog/reorderBuffer.sv
verilog/operandStage.sv
verilog/renameCore.sv
bench/renameCoreTb.sv

//--- run.sh
#!/bin/sh
# Builds the rename core testbench with Verilator and runs it.
# The run fails when the log holds the testbench's failure line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module renameCoreTb -f files.f -o renameCoreTb; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/renameCoreTb > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi

exit 0

//--- bench/renameCoreTb.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module renameCoreTb;
    import renamePkg::*;

    // the tests take about 400 cycles in all, so this leaves a wide margin.
    localparam int MaxCycles = 2000;
    localparam int NumTags = 2 ** `RENAME_TAG_W;

    logic         clk;
    logic         rst;
    logic         dispCyc;
    logic         dispStb;
    logic         dispWe;
    dispatchReq_t dispDat;
    logic         dispAck;
    completion_t  cmpl;
    logic         issueValid;
    logic         issueReady;
    renamedOp_t   issueOp;
    retire_t      retire;

    // reference model.
    // committed values, the latest writer per register, and per tag its rd,
    // whether it has completed and with what data.
    data_t      archReg   [`RENAME_NREGS];
    tag_t       latestTag [`RENAME_NREGS];
    logic       tagDone   [NumTags];
    data_t      tagData   [NumTags];
    regIdx_t    rdOfTag   [NumTags];
    tag_t       nextTag;
    tag_t       retireOrder [$];
    renamedOp_t toResolve   [$];
    renamedOp_t expIssue    [$];

    string      testName;
    int         issueErrors;
    int         retireErrors;
    int         ctrlErrors;
    int         cycleCount;
    logic       ackBlocked;
    logic       stallSeen;
    renamedOp_t stallOp;

    renameCore DUT (
        .clk        (clk),
        .rst        (rst),
        .dispCyc    (dispCyc),
        .dispStb    (dispStb),
        .dispWe     (dispWe),
        .dispDat    (dispDat),
        .dispAck    (dispAck),
        .cmpl       (cmpl),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .issueOp    (issueOp),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // a source as the model sees it at the dispatch event.
    // register 0 and registers without a writer in flight are ready.
    function automatic srcOperand_t renameSrc(regIdx_t rs);
        srcOperand_t src;
        src = '0;
        if (rs == '0) begin
            src.ready = 1'b1;
        end else if (latestTag[rs] == '0) begin
            src.ready = 1'b1;
            src.value = archReg[rs];
        end else begin
            src.tag = latestTag[rs];
        end
        return src;
    endfunction

    // a pending source picks up its producer's result once that has completed.
    function automatic srcOperand_t resolveSrc(srcOperand_t src);
        srcOperand_t res;
        res = src;
        if (!src.ready && tagDone[src.tag]) begin
            res.ready = 1'b1;
            res.tag   = '0;
            res.value = tagData[src.tag];
        end
        return res;
    endfunction

    task automatic requestOp(input regIdx_t rd, input regIdx_t rs1, input regIdx_t rs2);
        dispCyc     = 1'b1;
        dispStb     = 1'b1;
        dispWe      = 1'b1;
        dispDat.rd  = rd;
        dispDat.rs1 = rs1;
        dispDat.rs2 = rs2;
    endtask

    // wait for ack, end the bus cycle, then rename in the model.
    // sources are read before rd gets its new tag.
    task automatic awaitAck(output tag_t tag);
        renamedOp_t op;
        @(posedge clk);
        while (!dispAck) begin
            @(posedge clk);
        end
        #1;
        dispCyc = 1'b0;
        dispStb = 1'b0;
        dispWe  = 1'b0;
        tag     = nextTag;
        op.tag  = nextTag;
        op.rd   = dispDat.rd;
        op.src1 = renameSrc(dispDat.rs1);
        op.src2 = renameSrc(dispDat.rs2);
        if (dispDat.rd != '0) begin
            latestTag[dispDat.rd] = nextTag;
        end
        rdOfTag[nextTag] = dispDat.rd;
        tagDone[nextTag] = 1'b0;
        retireOrder.push_back(nextTag);
        toResolve.push_back(op);
        nextTag = (nextTag == `RENAME_ROB_SLOTS) ? tag_t'(1) : nextTag + tag_t'(1);
    endtask

    task automatic dispatchOp(input regIdx_t rd, input regIdx_t rs1, input regIdx_t rs2,
                              output tag_t tag);
        requestOp(rd, rs1, rs2);
        awaitAck(tag);
    endtask

    // one cycle on the completion bus.
    task automatic completeOp(input tag_t tag, input data_t data);
        cmpl.valid   = 1'b1;
        cmpl.tag     = tag;
        cmpl.data    = data;
        tagDone[tag] = 1'b1;
        tagData[tag] = data;
        @(posedge clk);
        #1;
        cmpl = '0;
    endtask

    task automatic waitRetired(input int left);
        @(posedge clk);
        while (retireOrder.size() > left) begin
            @(posedge clk);
        end
        #1;
    endtask

    // returns once every instruction has issued and retired.
    task automatic drain();
        @(posedge clk);
        while (retireOrder.size() != 0 || expIssue.size() != 0 || toResolve.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    always @(posedge clk) begin
        renamedOp_t exp;
        retire_t    expRet;
        if (!rst && issueValid && issueReady) begin
            if (expIssue.size() == 0) begin
                $display("issue fired in test %s with no instruction outstanding", testName);
                issueErrors++;
            end else begin
                exp = expIssue.pop_front();
                assert (issueOp == exp) else begin
                    $display("FAIL %s issueOp expected %h actual %h", testName, exp, issueOp);
                    issueErrors++;
                end
            end
        end
        if (!rst && retire.valid) begin
            if (retireOrder.size() == 0) begin
                $display("retire fired in test %s with nothing in flight", testName);
                retireErrors++;
            end else begin
                expRet.valid = 1'b1;
                expRet.tag   = retireOrder.pop_front();
                expRet.rd    = rdOfTag[expRet.tag];
                expRet.data  = tagData[expRet.tag];
                assert (retire == expRet) else begin
                    $display("FAIL %s retire expected %h actual %h", testName, expRet, retire);
                    retireErrors++;
                end
                // only the latest writer of a register commits its value.
                if (expRet.rd != '0 && latestTag[expRet.rd] == expRet.tag) begin
                    archReg[expRet.rd]   = expRet.data;
                    latestTag[expRet.rd] = '0;
                end
            end
        end
        // an op renamed after its ack has passed operand resolution by this edge.
        while (toResolve.size() != 0) begin
            exp      = toResolve.pop_front();
            exp.src1 = resolveSrc(exp.src1);
            exp.src2 = resolveSrc(exp.src2);
            expIssue.push_back(exp);
        end
    end

    // remembers a stalled issue so the next cycle can be compared with it.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            stallSeen <= 1'b0;
            stallOp   <= '0;
        end else begin
            stallSeen <= issueValid && !issueReady;
            stallOp   <= issueOp;
        end
    end

    assert property (@(posedge clk) rst |-> (!dispAck && !issueValid && !retire.valid))
        else begin
            $display("dispAck, issueValid or retireValid was high during reset");
            ctrlErrors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     stallSeen |-> (issueValid && issueOp == stallOp))
        else begin
            $display("FAIL %s stalled issueOp expected %h actual %h", testName, stallOp, issueOp);
            ctrlErrors++;
        end

    assert property (@(posedge clk) disable iff (rst) ackBlocked |-> !dispAck)
        else begin
            $display("dispAck rose in test %s although no slot was free", testName);
            ctrlErrors++;
        end

    initial begin
        cycleCount = 0;
        while (cycleCount < MaxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", MaxCycles);
        $display("errors: issue %0d, retire %0d, control %0d",
                 issueErrors, retireErrors, ctrlErrors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        tag_t tagA;
        tag_t tagB;
        tag_t tagC;
        tag_t tagD;
        tag_t fullTags [16];
        rst          = 1'b1;
        dispCyc      = 1'b0;
        dispStb      = 1'b0;
        dispWe       = 1'b0;
        dispDat      = '0;
        cmpl         = '0;
        issueReady   = 1'b1;
        ackBlocked   = 1'b0;
        issueErrors  = 0;
        retireErrors = 0;
        ctrlErrors   = 0;
        testName     = "reset";
        nextTag      = tag_t'(1);
        for (int i = 0; i < `RENAME_NREGS; i++) begin
            archReg[i]   = '0;
            latestTag[i] = '0;
        end
        for (int i = 0; i < NumTags; i++) begin
            tagDone[i] = 1'b0;
            tagData[i] = '0;
            rdOfTag[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!dispAck && !issueValid && !retire.valid) else begin
            $display("outputs not idle right after reset");
            ctrlErrors++;
        end

        // every register reads as zero straight after reset.
        dispatchOp(5'd1, 5'd5, 5'd0, tagA);
        completeOp(tagA, 32'h1111_0001);
        drain();

        testName = "ready";
        dispatchOp(5'd2, 5'd1, 5'd0, tagA);
        completeOp(tagA, 32'h2222_0002);
        drain();
        dispatchOp(5'd3, 5'd1, 5'd2, tagA);
        completeOp(tagA, 32'h3333_0003);
        drain();

        // B stays pending, C resolves from the bus in its own cycle and D
        // sees A already done.
        testName = "pending";
        dispatchOp(5'd4, 5'd1, 5'd2, tagA);
        dispatchOp(5'd5, 5'd4, 5'd3, tagB);
        dispatchOp(5'd6, 5'd4, 5'd0, tagC);
        completeOp(tagA, 32'h4444_0004);
        dispatchOp(5'd7, 5'd4, 5'd5, tagD);
        completeOp(tagB, 32'h5555_0005);
        completeOp(tagD, 32'h7777_0007);
        completeOp(tagC, 32'h6666_0006);
        drain();

        // completions in reverse, one of them a write to register 0.
        testName = "order";
        dispatchOp(5'd8, 5'd4, 5'd0, tagA);
        dispatchOp(5'd9, 5'd5, 5'd8, tagB);
        dispatchOp(5'd0, 5'd6, 5'd7, tagC);
        dispatchOp(5'd10, 5'd0, 5'd9, tagD);
        completeOp(tagD, 32'h8888_000a);
        completeOp(tagC, 32'hdead_0000);
        completeOp(tagB, 32'h8888_0009);
        completeOp(tagA, 32'h8888_0008);
        drain();
        dispatchOp(5'd11, 5'd8, 5'd9, tagA);
        dispatchOp(5'd12, 5'd10, 5'd0, tagB);
        completeOp(tagB, 32'h8888_000c);
        completeOp(tagA, 32'h8888_000b);
        drain();

        // two writers of r14; the older one retires without touching it.
        testName = "latest";
        dispatchOp(5'd14, 5'd1, 5'd0, tagA);
        dispatchOp(5'd14, 5'd2, 5'd0, tagB);
        completeOp(tagA, 32'h9999_0001);
        waitRetired(1);
        // the reader issues while r14 still waits on the newer writer.
        dispatchOp(5'd15, 5'd14, 5'd0, tagC);
        completeOp(tagC, 32'h9999_0003);
        completeOp(tagB, 32'h9999_0002);
        drain();
        dispatchOp(5'd16, 5'd14, 5'd0, tagA);
        completeOp(tagA, 32'h9999_0004);
        drain();

        // stage B and stage A fill up, then the third request waits.
        testName   = "stall";
        issueReady = 1'b0;
        dispatchOp(5'd20, 5'd1, 5'd2, tagA);
        dispatchOp(5'd21, 5'd3, 5'd0, tagB);
        ackBlocked = 1'b1;
        requestOp(5'd22, 5'd4, 5'd5);
        repeat (6) @(posedge clk);
        #1;
        ackBlocked = 1'b0;
        issueReady = 1'b1;
        awaitAck(tagC);
        completeOp(tagA, 32'haaaa_0014);
        completeOp(tagB, 32'haaaa_0015);
        completeOp(tagC, 32'haaaa_0016);
        drain();

        // fifteen ops in flight fill the reorder buffer.
        testName = "full";
        for (int i = 0; i < `RENAME_ROB_SLOTS; i++) begin
            dispatchOp(regIdx_t'(i + 1), regIdx_t'(i), 5'd20, fullTags[i]);
        end
        ackBlocked = 1'b1;
        requestOp(5'd16, 5'd15, 5'd21);
        repeat (6) @(posedge clk);
        #1;
        ackBlocked = 1'b0;
        completeOp(fullTags[0], 32'hf000_0000);
        awaitAck(fullTags[15]);
        for (int i = 15; i > 0; i--) begin
            completeOp(fullTags[i], 32'hf000_0000 | data_t'(i));
        end
        drain();

        $display("errors: issue %0d, retire %0d, control %0d",
                 issueErrors, retireErrors, ctrlErrors);
        if (issueErrors + retireErrors + ctrlErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/renameCore.sv
`timescale 1ns/1ps

module renameCore (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispCyc,
    input  logic                    dispStb,
    input  logic                    dispWe,
    input  renamePkg::dispatchReq_t dispDat,
    output logic                    dispAck,
    input  renamePkg::completion_t  cmpl,
    output logic                    issueValid,
    input  logic                    issueReady,
    output renamePkg::renamedOp_t   issueOp,
    output renamePkg::retire_t      retire
);
    import renamePkg::*;

    // dispatch to reorder buffer.
    tag_t robAllocTag;
    logic robFull;
    logic robAlloc;

    // dispatch to register status file.
    regIdx_t rs1Idx;
    regIdx_t rs2Idx;
    data_t   rs1Value;
    data_t   rs2Value;
    tag_t    rs1Tag;
    tag_t    rs2Tag;
    logic    tagWrite;
    regIdx_t tagWriteIdx;

    // dispatch into stage A.
    logic       dispValid;
    logic       dispReady;
    renamedOp_t dispOp;

    // stage A into the operand stage.
    logic       aValid;
    logic       aReady;
    renamedOp_t aOp;

    // operand stage into stage B.
    logic       resValid;
    logic       resReady;
    renamedOp_t resOp;

    // operand stage lookups into the reorder buffer.
    tag_t  lookupTag1;
    tag_t  lookupTag2;
    logic  lookupDone1;
    logic  lookupDone2;
    data_t lookupData1;
    data_t lookupData2;

    dispatchStage dispatch (
        .clk         (clk),
        .rst         (rst),
        .dispCyc     (dispCyc),
        .dispStb     (dispStb),
        .dispWe      (dispWe),
        .dispDat     (dispDat),
        .dispAck     (dispAck),
        .robAllocTag (robAllocTag),
        .robFull     (robFull),
        .robAlloc    (robAlloc),
        .rs1Idx      (rs1Idx),
        .rs2Idx      (rs2Idx),
        .rs1Value    (rs1Value),
        .rs2Value    (rs2Value),
        .rs1Tag      (rs1Tag),
        .rs2Tag      (rs2Tag),
        .tagWrite    (tagWrite),
        .tagWriteIdx (tagWriteIdx),
        .outValid    (dispValid),
        .outReady    (dispReady),
        .outOp       (dispOp)
    );

    // the new producer tag is the one the reorder buffer hands out.
    regStatusFile regFile (
        .clk         (clk),
        .rst         (rst),
        .rs1Idx      (rs1Idx),
        .rs2Idx      (rs2Idx),
        .rs1Value    (rs1Value),
        .rs2Value    (rs2Value),
        .rs1Tag      (rs1Tag),
        .rs2Tag      (rs2Tag),
        .tagWrite    (tagWrite),
        .tagWriteIdx (tagWriteIdx),
        .tagWriteTag (robAllocTag),
        .retire      (retire)
    );

    reorderBuffer rob (
        .clk         (clk),
        .rst         (rst),
        .alloc       (robAlloc),
        .allocRd     (dispDat.rd),
        .allocTag    (robAllocTag),
        .full        (robFull),
        .cmpl        (cmpl),
        .lookupTag1  (lookupTag1),
        .lookupTag2  (lookupTag2),
        .lookupDone1 (lookupDone1),
        .lookupDone2 (lookupDone2),
        .lookupData1 (lookupData1),
        .lookupData2 (lookupData2),
        .retire      (retire)
    );

    stageReg #(.payload_t(renamedOp_t)) stageA (
        .clk      (clk),
        .rst      (rst),
        .inValid  (dispValid),
        .inReady  (dispReady),
        .inData   (dispOp),
        .outValid (aValid),
        .outReady (aReady),
        .outData  (aOp)
    );

    operandStage operands (
        .inValid     (aValid),
        .inReady     (aReady),
        .inOp        (aOp),
        .lookupTag1  (lookupTag1),
        .lookupTag2  (lookupTag2),
        .lookupDone1 (lookupDone1),
        .lookupDone2 (lookupDone2),
        .lookupData1 (lookupData1),
        .lookupData2 (lookupData2),
        .cmpl        (cmpl),
        .outValid    (resValid),
        .outReady    (resReady),
        .outOp       (resOp)
    );

    // stage B drives the issue port and holds its op while issueReady is low.
    stageReg #(.payload_t(renamedOp_t)) stageB (
        .clk      (clk),
        .rst      (rst),
        .inValid  (resValid),
        .inReady  (resReady),
        .inData   (resOp),
        .outValid (issueValid),
        .outReady (issueReady),
        .outData  (issueOp)
    );

endmodule

//--- verilog/operandStage.sv
`timescale 1ns/1ps

module operandStage (
    input  logic                   inValid,
    output logic                   inReady,
    input  renamePkg::renamedOp_t  inOp,
    output renamePkg::tag_t        lookupTag1,
    output renamePkg::tag_t        lookupTag2,
    input  logic                   lookupDone1,
    input  logic                   lookupDone2,
    input  renamePkg::data_t       lookupData1,
    input  renamePkg::data_t       lookupData2,
    input  renamePkg::completion_t cmpl,
    output logic                   outValid,
    input  logic                   outReady,
    output renamePkg::renamedOp_t  outOp
);
    import renamePkg::*;

    // a pending source picks up its value from a finished reorder buffer slot
    // or from a completion that arrives in this very cycle.
    // a resolved source drops its tag, the same as a source that was ready
    // at dispatch.
    function automatic srcOperand_t resolve(srcOperand_t src, logic robDone,
                                            data_t robData, completion_t bus);
        srcOperand_t res;
        res = src;
        if (!src.ready) begin
            if (robDone) begin
                res.ready = 1'b1;
                res.tag   = '0;
                res.value = robData;
            end else if (bus.valid && (bus.tag == src.tag)) begin
                res.ready = 1'b1;
                res.tag   = '0;
                res.value = bus.data;
            end
        end
        return res;
    endfunction

    // the stage has no storage, so handshakes pass straight through.
    assign inReady  = outReady;
    assign outValid = inValid;

    assign lookupTag1 = inOp.src1.tag;
    assign lookupTag2 = inOp.src2.tag;

    always_comb begin
        outOp      = inOp;
        outOp.src1 = resolve(inOp.src1, lookupDone1, lookupData1, cmpl);
        outOp.src2 = resolve(inOp.src2, lookupDone2, lookupData2, cmpl);
    end

endmodule

//--- verilog/reorderBuffer.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module reorderBuffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc,
    input  renamePkg::regIdx_t     allocRd,
    output renamePkg::tag_t        allocTag,
    output logic                   full,
    input  renamePkg::completion_t cmpl,
    input  renamePkg::tag_t        lookupTag1,
    input  renamePkg::tag_t        lookupTag2,
    output logic                   lookupDone1,
    output logic                   lookupDone2,
    output renamePkg::data_t       lookupData1,
    output renamePkg::data_t       lookupData2,
    output renamePkg::retire_t     retire
);
    import renamePkg::*;

    localparam int Slots = `RENAME_ROB_SLOTS;

    typedef logic [$clog2(Slots)-1:0] slotIdx_t;

    // slot i holds tag i+1, so head and tail never produce tag 0.
    slotIdx_t                   headIdx;
    slotIdx_t                   tailIdx;
    logic [$clog2(Slots+1)-1:0] count;

    regIdx_t slotRd   [Slots];
    logic    slotDone [Slots];
    data_t   slotData [Slots];

    logic allocNow;
    logic retireNow;

    function automatic slotIdx_t nextIdx(slotIdx_t idx);
        return (idx == slotIdx_t'(Slots - 1)) ? '0 : idx + 1'b1;
    endfunction

    function automatic tag_t idxToTag(slotIdx_t idx);
        return tag_t'(idx) + 1'b1;
    endfunction

    function automatic slotIdx_t tagToIdx(tag_t tag);
        return slotIdx_t'(tag - 1'b1);
    endfunction

    assign full     = (count == Slots);
    assign allocTag = idxToTag(tailIdx);
    assign allocNow = alloc && !full;

    // the head leaves once its result is in.
    // done is registered, so a completion retires one edge after it is marked.
    assign retireNow = (count != '0) && slotDone[headIdx];

    // lookups for operand resolution.
    // tag 0 never names a slot and reads as not done.
    assign lookupDone1 = (lookupTag1 != '0) && slotDone[tagToIdx(lookupTag1)];
    assign lookupDone2 = (lookupTag2 != '0) && slotDone[tagToIdx(lookupTag2)];
    assign lookupData1 = (lookupTag1 != '0) ? slotData[tagToIdx(lookupTag1)] : '0;
    assign lookupData2 = (lookupTag2 != '0) ? slotData[tagToIdx(lookupTag2)] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            headIdx <= '0;
            tailIdx <= '0;
            count   <= '0;
        end else begin
            if (allocNow) begin
                tailIdx <= nextIdx(tailIdx);
            end
            if (retireNow) begin
                headIdx <= nextIdx(headIdx);
            end
            case ({allocNow, retireNow})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // slot contents.
    // done and data of a freed slot stay put until the slot is allocated
    // again, which keeps late lookups of a retired tag correct.
    always_ff @(posedge clk) begin
        if (cmpl.valid && (cmpl.tag != '0)) begin
            slotDone[tagToIdx(cmpl.tag)] <= 1'b1;
            slotData[tagToIdx(cmpl.tag)] <= cmpl.data;
        end
        if (allocNow) begin
            slotDone[tailIdx] <= 1'b0;
            slotRd[tailIdx]   <= allocRd;
        end
    end

    // retire bus is registered, valid for exactly one cycle per entry.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire <= '0;
        end else begin
            retire.valid <= retireNow;
            if (retireNow) begin
                retire.tag  <= idxToTag(headIdx);
                retire.rd   <= slotRd[headIdx];
                retire.data <= slotData[headIdx];
            end
        end
    end

endmodule

//--- verilog/regStatusFile.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module regStatusFile (
    input  logic               clk,
    input  logic               rst,
    input  renamePkg::regIdx_t rs1Idx,
    input  renamePkg::regIdx_t rs2Idx,
    output renamePkg::data_t   rs1Value,
    output renamePkg::data_t   rs2Value,
    output renamePkg::tag_t    rs1Tag,
    output renamePkg::tag_t    rs2Tag,
    input  logic               tagWrite,
    input  renamePkg::regIdx_t tagWriteIdx,
    input  renamePkg::tag_t    tagWriteTag,
    input  renamePkg::retire_t retire
);
    import renamePkg::*;

    // architectural values and, per register, the tag of the latest writer
    // still in flight.
    data_t regValue [`RENAME_NREGS];
    tag_t  regTag   [`RENAME_NREGS];

    logic retireHit;

    // both read ports are combinational.
    assign rs1Value = regValue[rs1Idx];
    assign rs2Value = regValue[rs2Idx];
    assign rs1Tag   = regTag[rs1Idx];
    assign rs2Tag   = regTag[rs2Idx];

    // only the latest writer of a register may update it.
    // an older retire whose tag was overwritten by a newer dispatch is dropped.
    assign retireHit = retire.valid && (retire.rd != '0) && (regTag[retire.rd] == retire.tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RENAME_NREGS; i++) begin
                regValue[i] <= '0;
            end
        end else if (retireHit) begin
            regValue[retire.rd] <= retire.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RENAME_NREGS; i++) begin
                regTag[i] <= '0;
            end
        end else begin
            // a matching retire leaves the register with no pending producer.
            if (retireHit) begin
                regTag[retire.rd] <= '0;
            end
            // the dispatch write comes last, so it wins over a same-cycle
            // retire to the same register.
            // register 0 never gets a producer.
            if (tagWrite && (tagWriteIdx != '0)) begin
                regTag[tagWriteIdx] <= tagWriteTag;
            end
        end
    end

endmodule

//--- verilog/dispatchStage.sv
`timescale 1ns/1ps

module dispatchStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispCyc,
    input  logic                    dispStb,
    input  logic                    dispWe,
    input  renamePkg::dispatchReq_t dispDat,
    output logic                    dispAck,
    input  renamePkg::tag_t         robAllocTag,
    input  logic                    robFull,
    output logic                    robAlloc,
    output renamePkg::regIdx_t      rs1Idx,
    output renamePkg::regIdx_t      rs2Idx,
    input  renamePkg::data_t        rs1Value,
    input  renamePkg::data_t        rs2Value,
    input  renamePkg::tag_t         rs1Tag,
    input  renamePkg::tag_t         rs2Tag,
    output logic                    tagWrite,
    output renamePkg::regIdx_t      tagWriteIdx,
    output logic                    outValid,
    input  logic                    outReady,
    output renamePkg::renamedOp_t   outOp
);
    import renamePkg::*;

    logic accept;

    // a source with no producer is ready with the register value.
    // register 0 is forced ready with zero whatever the file returns.
    function automatic srcOperand_t buildSrc(regIdx_t idx, tag_t tag, data_t value);
        srcOperand_t src;
        src.ready = (idx == '0) || (tag == '0);
        src.tag   = src.ready ? '0 : tag;
        src.value = (idx == '0 || !src.ready) ? '0 : value;
        return src;
    endfunction

    // a write request is taken when a reorder buffer slot is free and the
    // first stage register can take the op.
    // the ack cycle itself is excluded because the master still holds stb there.
    assign accept = dispCyc && dispStb && dispWe && !dispAck && !robFull && outReady;

    // ack follows the accepted request by one cycle, for one cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dispAck <= 1'b0;
        end else begin
            dispAck <= accept;
        end
    end

    // the ack cycle is the dispatch event.
    // old operand state is read now and the new tag lands in the file at the
    // closing edge, so a source equal to rd still sees the previous producer.
    assign rs1Idx      = dispDat.rs1;
    assign rs2Idx      = dispDat.rs2;
    assign robAlloc    = dispAck;
    assign tagWrite    = dispAck && (dispDat.rd != '0);
    assign tagWriteIdx = dispDat.rd;
    assign outValid    = dispAck;

    always_comb begin
        outOp.tag  = robAllocTag;
        outOp.rd   = dispDat.rd;
        outOp.src1 = buildSrc(dispDat.rs1, rs1Tag, rs1Value);
        outOp.src2 = buildSrc(dispDat.rs2, rs2Tag, rs2Value);
    end

endmodule

//--- verilog/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,
    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);

    logic     validQ;
    payload_t dataQ;

    // the register takes a new item when it is empty or when its current
    // item leaves in the same cycle, so a full pipeline keeps streaming.
    assign inReady  = !validQ || outReady;
    assign outValid = validQ;
    assign outData  = dataQ;

    // the valid flag follows the input whenever the register can take an item.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (inReady) begin
            validQ <= inValid;
        end
    end

    // payload is captured on every accepted transfer.
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            dataQ <= inData;
        end
    end

endmodule

//--- verilog/renamePkg.sv
`include "rename_consts.svh"

package renamePkg;

    // scalar building blocks shared by every stage.
    typedef logic [`RENAME_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`RENAME_NREGS)-1:0] regIdx_t;
    typedef logic [`RENAME_XLEN-1:0] data_t;

    // one decoded instruction as it arrives on the dispatch port.
    typedef struct packed {
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
    } dispatchReq_t;

    // a source operand is either ready with a value or pending on a producer tag.
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } srcOperand_t;

    // the renamed operation that travels through both stage registers.
    typedef struct packed {
        tag_t        tag;
        regIdx_t     rd;
        srcOperand_t src1;
        srcOperand_t src2;
    } renamedOp_t;

    // result bus from the execution units, always accepted.
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } completion_t;

    // in-order retire bus toward the register file and the outside.
    typedef struct packed {
        logic    valid;
        tag_t    tag;
        regIdx_t rd;
        data_t   data;
    } retire_t;

endpackage

//--- verilog/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// width of a reorder buffer tag.
// tag 0 is reserved and means the register has no producer in flight.
`define RENAME_TAG_W 4

// usable reorder buffer slots, one for every nonzero tag.
`define RENAME_ROB_SLOTS 15

// width of an architectural data word.
`define RENAME_XLEN 32

// number of architectural integer registers.
// register 0 always reads as zero.
`define RENAME_NREGS 32

`endif
